// File: source/shell_pkg.sv
package shell_pkg;

	// bus widths.
	localparam int ADDR_W  = 21;
	localparam int DATA_W  = 32;
	localparam int MEM_AW  = 12; // 4096 data words.
	localparam int COUNT_W = 10; // job count field in descriptor word 0.

	// flag register location and codes.
	localparam logic [ADDR_W-1:0] FLAG_ADDR = 21'h7FFFE;
	localparam logic [DATA_W-1:0] CMD_START = 32'h0001_0000;
	localparam logic [DATA_W-1:0] FLAG_ACK  = 32'h0000_0002;
	localparam logic [DATA_W-1:0] FLAG_DONE = 32'h0000_0004;

	// one host port cycle.
	typedef struct packed {
		logic              wr_en;
		logic              rd_en;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} host_req_t;

	// one kernel request, kernel byte order.
	typedef struct packed {
		logic              req;
		logic              rd_wr;    // 0 read, 1 write.
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              set_done; // single cycle pulse.
	} user_req_t;

	// one fpga port cycle, memory byte order.
	typedef struct packed {
		logic              rd_req;
		logic              wr_en;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} fpga_req_t;

	// job control states.
	typedef enum logic [2:0] {
		INIT,
		WAIT,
		READ,
		WRITE,
		DONE
	} ctrl_state_t;

	// kernel states.
	typedef enum logic [2:0] {
		IDLE,
		GET_COUNT,
		SUM,
		STORE,
		FINISH
	} kern_state_t;

endpackage : shell_pkg

// File: source/shared_mem.sv
`timescale 1ns/10ps

module shared_mem (
	input  logic                         clk,
	input  logic                         rst_n,
	input  shell_pkg::host_req_t         host_req,
	output logic [shell_pkg::DATA_W-1:0] host_rd_data,
	output logic                         host_rd_valid,
	input  shell_pkg::fpga_req_t         fpga_req,
	output logic [shell_pkg::DATA_W-1:0] rd_data,
	output logic                         rd_ready,
	input  logic                         flag_we,
	input  logic [shell_pkg::DATA_W-1:0] out_flag
);

	logic [shell_pkg::DATA_W-1:0] mem [0:(1 << shell_pkg::MEM_AW)-1];
	logic [shell_pkg::DATA_W-1:0] flag_q;
	logic [shell_pkg::MEM_AW-1:0] host_idx;
	logic [shell_pkg::MEM_AW-1:0] fpga_idx;
	logic                         host_is_flag;
	logic                         fpga_is_flag;

	// high address bits fold away.
	assign host_idx     = host_req.addr[shell_pkg::MEM_AW-1:0];
	assign fpga_idx     = fpga_req.addr[shell_pkg::MEM_AW-1:0];
	assign host_is_flag = host_req.addr == shell_pkg::FLAG_ADDR;
	assign fpga_is_flag = fpga_req.addr == shell_pkg::FLAG_ADDR;

	// array powers up cleared.
	initial begin
		for (int i = 0; i < (1 << shell_pkg::MEM_AW); i++)
			mem[i] = '0;
	end

	// both write ports, fpga last so it wins a collision.
	always_ff @(posedge clk) begin
		if (host_req.wr_en && !host_is_flag)
			mem[host_idx] <= host_req.wdata;
		if (fpga_req.wr_en && !fpga_is_flag)
			mem[fpga_idx] <= fpga_req.wdata;
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			flag_q <= '0;
		else if (flag_we)
			flag_q <= out_flag; // controller has priority.
		else if (host_req.wr_en && host_is_flag)
			flag_q <= host_req.wdata;
	end

	// registered reads, one cycle latency.
	always_ff @(posedge clk) begin
		host_rd_data <= host_is_flag ? flag_q : mem[host_idx];
		rd_data      <= fpga_is_flag ? flag_q : mem[fpga_idx];
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			host_rd_valid <= 1'b0;
			rd_ready      <= 1'b0;
		end else begin
			host_rd_valid <= host_req.rd_en;
			rd_ready      <= fpga_req.rd_req;
		end
	end

endmodule : shared_mem

// File: source/shell_ctrl.sv
`timescale 1ns/10ps

module shell_ctrl (
	input  logic                         clk,
	input  logic                         rst_n,
	input  shell_pkg::host_req_t         host_req,
	input  shell_pkg::user_req_t         user_req,
	input  logic [shell_pkg::DATA_W-1:0] rd_data,
	input  logic                         rd_ready,
	output shell_pkg::fpga_req_t         fpga_req,
	output logic                         flag_we,
	output logic [shell_pkg::DATA_W-1:0] out_flag,
	output logic                         ready_2_start,
	output logic [shell_pkg::DATA_W-1:0] user_rd_data,
	output logic                         user_rd_ready
);

	shell_pkg::ctrl_state_t cs, ns;
	logic start_cmd;

	// reverse byte order between kernel and memory.
	function automatic logic [shell_pkg::DATA_W-1:0] byte_swap(
		input logic [shell_pkg::DATA_W-1:0] w
	);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// host writes the start command into the flag word.
	assign start_cmd = host_req.wr_en && (host_req.addr == shell_pkg::FLAG_ADDR)
		&& (host_req.wdata == shell_pkg::CMD_START);

	// read data goes straight back to the kernel.
	assign user_rd_data  = byte_swap(rd_data);
	assign user_rd_ready = rd_ready;

	always_comb begin
		fpga_req.rd_req = 1'b0;
		fpga_req.wr_en  = 1'b0;
		fpga_req.addr   = user_req.addr;
		fpga_req.wdata  = byte_swap(user_req.wdata);
		flag_we         = 1'b0;
		out_flag        = '0;
		ready_2_start   = 1'b0;
		ns              = cs;
		case (cs)
			shell_pkg::INIT: begin
				if (start_cmd) begin
					flag_we  = 1'b1; // acknowledge at the same edge.
					out_flag = shell_pkg::FLAG_ACK;
					ns       = shell_pkg::WAIT;
				end
			end
			shell_pkg::WAIT,
			shell_pkg::READ,
			shell_pkg::WRITE: begin
				ready_2_start = 1'b1;
				if (user_req.req) begin
					fpga_req.wr_en  = user_req.rd_wr;
					fpga_req.rd_req = !user_req.rd_wr;
				end
				// last write of a job can come with set_done.
				if (user_req.set_done)
					ns = shell_pkg::DONE;
				else if (user_req.req)
					ns = user_req.rd_wr ? shell_pkg::WRITE : shell_pkg::READ;
				else
					ns = shell_pkg::WAIT;
			end
			shell_pkg::DONE: begin
				flag_we  = 1'b1; // post completion.
				out_flag = shell_pkg::FLAG_DONE;
				ns       = shell_pkg::INIT;
			end
			default: ns = shell_pkg::INIT;
		endcase
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			cs <= shell_pkg::INIT;
		else
			cs <= ns;
	end

endmodule : shell_ctrl

// File: source/checksum_kernel.sv
`timescale 1ns/10ps

module checksum_kernel (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         ready_2_start,
	input  logic [shell_pkg::DATA_W-1:0] user_rd_data,
	input  logic                         user_rd_ready,
	output shell_pkg::user_req_t         user_req
);

	shell_pkg::kern_state_t state, state_nxt;

	logic                          r2s_q;
	logic                          start;
	logic [shell_pkg::COUNT_W-1:0] count;
	logic [shell_pkg::COUNT_W:0]   issue_addr;  // next data address to read.
	logic [shell_pkg::COUNT_W:0]   rcv_cnt;     // words summed so far.
	logic [shell_pkg::COUNT_W:0]   store_addr;
	logic                          issue_more;
	logic                          last_word;
	logic [shell_pkg::DATA_W-1:0]  sum;

	assign start      = ready_2_start && !r2s_q; // rising edge.
	assign issue_more = issue_addr <= {1'b0, count};
	assign last_word  = user_rd_ready && (rcv_cnt + 1'b1 == {1'b0, count});
	assign store_addr = {1'b0, count} + 1'b1;  // result sits after the data.

	always_comb begin
		user_req  = '0;
		state_nxt = state;
		case (state)
			shell_pkg::IDLE: begin
				if (start) begin
					user_req.req = 1'b1; // descriptor read at address 0.
					state_nxt    = shell_pkg::GET_COUNT;
				end
			end
			shell_pkg::GET_COUNT: begin
				if (user_rd_ready) begin
					if (user_rd_data[shell_pkg::COUNT_W-1:0] == '0)
						state_nxt = shell_pkg::STORE;
					else
						state_nxt = shell_pkg::SUM;
				end
			end
			shell_pkg::SUM: begin
				if (issue_more) begin
					user_req.req  = 1'b1;
					user_req.addr = {{(shell_pkg::ADDR_W-shell_pkg::COUNT_W-1){1'b0}},
						issue_addr};
				end
				if (last_word)
					state_nxt = shell_pkg::STORE;
			end
			shell_pkg::STORE: begin
				user_req.req      = 1'b1;
				user_req.rd_wr    = 1'b1;
				user_req.addr     = {{(shell_pkg::ADDR_W-shell_pkg::COUNT_W-1){1'b0}},
					store_addr};
				user_req.wdata    = sum;
				user_req.set_done = 1'b1;
				state_nxt         = shell_pkg::FINISH;
			end
			shell_pkg::FINISH: begin
				// wait for the controller to leave the job.
				if (!ready_2_start)
					state_nxt = shell_pkg::IDLE;
			end
			default: state_nxt = shell_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state      <= shell_pkg::IDLE;
			r2s_q      <= 1'b0;
			count      <= '0;
			issue_addr <= '0;
			rcv_cnt    <= '0;
		end else begin
			state <= state_nxt;
			r2s_q <= ready_2_start;
			if (state == shell_pkg::GET_COUNT && user_rd_ready) begin
				count      <= user_rd_data[shell_pkg::COUNT_W-1:0];
				issue_addr <= 1;
				rcv_cnt    <= '0;
			end
			if (state == shell_pkg::SUM) begin
				if (issue_more)
					issue_addr <= issue_addr + 1'b1;
				if (user_rd_ready)
					rcv_cnt <= rcv_cnt + 1'b1;
			end
		end
	end

	// running checksum, cleared when the descriptor arrives.
	always_ff @(posedge clk) begin
		if (state == shell_pkg::GET_COUNT && user_rd_ready)
			sum <= '0;
		else if (state == shell_pkg::SUM && user_rd_ready)
			sum <= sum + user_rd_data; // wraps mod 2^32.
	end

endmodule : checksum_kernel

// File: source/shell_top.sv
`timescale 1ns/10ps

module shell_top (
	input  logic                         clk,
	input  logic                         rst_n,
	input  shell_pkg::host_req_t         host_req,
	output logic [shell_pkg::DATA_W-1:0] host_rd_data,
	output logic                         host_rd_valid
);

	shell_pkg::fpga_req_t         fpga_req;
	shell_pkg::user_req_t         user_req;
	logic [shell_pkg::DATA_W-1:0] rd_data;
	logic                         rd_ready;
	logic                         flag_we;
	logic [shell_pkg::DATA_W-1:0] out_flag;
	logic                         ready_2_start;
	logic [shell_pkg::DATA_W-1:0] user_rd_data;
	logic                         user_rd_ready;

	shared_mem u_mem (
		.clk           (clk),
		.rst_n         (rst_n),
		.host_req      (host_req),
		.host_rd_data  (host_rd_data),
		.host_rd_valid (host_rd_valid),
		.fpga_req      (fpga_req),
		.rd_data       (rd_data),
		.rd_ready      (rd_ready),
		.flag_we       (flag_we),
		.out_flag      (out_flag)
	);

	shell_ctrl u_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.host_req      (host_req),      // watched for the start command.
		.user_req      (user_req),
		.rd_data       (rd_data),
		.rd_ready      (rd_ready),
		.fpga_req      (fpga_req),
		.flag_we       (flag_we),
		.out_flag      (out_flag),
		.ready_2_start (ready_2_start),
		.user_rd_data  (user_rd_data),
		.user_rd_ready (user_rd_ready)
	);

	checksum_kernel u_kernel (
		.clk           (clk),
		.rst_n         (rst_n),
		.ready_2_start (ready_2_start),
		.user_rd_data  (user_rd_data),
		.user_rd_ready (user_rd_ready),
		.user_req      (user_req)
	);

endmodule : shell_top

// File: bench/shell_tb.sv
`timescale 1ns/10ps

module shell_tb;

	// five jobs of up to 64 words, single-cycle host writes, polling and margin.
	localparam int MAX_CYCLES = 20000;
	localparam int FLAG_POLLS = 200;

	logic                         clk;
	logic                         rst_n;
	shell_pkg::host_req_t         host_req;
	logic [shell_pkg::DATA_W-1:0] host_rd_data;
	logic                         host_rd_valid;

	logic [shell_pkg::DATA_W-1:0] job_words [1:64];
	logic [31:0]                  rng_state = 32'h2e9e47b1;
	string                        cur_test;
	int                           err_cnt;
	int                           test_start_errs;
	int                           pass_cnt;
	int                           fail_cnt;
	int                           cycle_cnt;

	shell_top DUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.host_req      (host_req),
		.host_rd_data  (host_rd_data),
		.host_rd_valid (host_rd_valid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("run stopped after %0d cycles without finishing", cycle_cnt);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// kernel sees every stored word with its bytes reversed.
	function automatic logic [31:0] byte_reverse(input logic [31:0] w);
		logic [31:0] r;
		for (int b = 0; b < 4; b++)
			r[8*b +: 8] = w[8*(3-b) +: 8];
		return r;
	endfunction

	task automatic check_word(input logic [shell_pkg::DATA_W-1:0] exp,
		input logic [shell_pkg::DATA_W-1:0] act);
		if (act !== exp) begin
			$display("MISMATCH %s word: expected %h, actual %h", cur_test, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_flag(input logic [shell_pkg::DATA_W-1:0] exp,
		input logic [shell_pkg::DATA_W-1:0] act);
		if (act !== exp) begin
			$display("MISMATCH %s flag: expected %h, actual %h", cur_test, exp, act);
			err_cnt++;
		end
	endtask

	// called on a falling edge, returns on the next one.
	task automatic host_write(input logic [shell_pkg::ADDR_W-1:0] addr,
		input logic [shell_pkg::DATA_W-1:0] data);
		host_req       = '0;
		host_req.wr_en = 1'b1;
		host_req.addr  = addr;
		host_req.wdata = data;
		@(negedge clk);
		host_req = '0;
	endtask

	// read data is due exactly one cycle after the rd_en cycle.
	task automatic host_read(input logic [shell_pkg::ADDR_W-1:0] addr,
		output logic [shell_pkg::DATA_W-1:0] data);
		host_req       = '0;
		host_req.rd_en = 1'b1;
		host_req.addr  = addr;
		@(negedge clk);
		host_req = '0;
		if (!host_rd_valid) begin
			$display("%s: host read of address %h gave no valid data one cycle later",
				cur_test, addr);
			err_cnt++;
		end
		data = host_rd_data;
	endtask

	task automatic wait_flag(input logic [shell_pkg::DATA_W-1:0] exp);
		logic [shell_pkg::DATA_W-1:0] val;
		int                           polls;
		polls = 0;
		host_read(shell_pkg::FLAG_ADDR, val);
		while (val !== exp && polls < FLAG_POLLS) begin
			host_read(shell_pkg::FLAG_ADDR, val);
			polls++;
		end
		if (val !== exp) begin
			$display("%s: flag did not reach %h within %0d polls, last read %h",
				cur_test, exp, FLAG_POLLS, val);
			err_cnt++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test        = name;
		test_start_errs = err_cnt;
	endtask

	task automatic end_test();
		if (err_cnt == test_start_errs) begin
			pass_cnt++;
			$display("%s: ok", cur_test);
		end else begin
			fail_cnt++;
			$display("%s: failed with %0d errors", cur_test, err_cnt - test_start_errs);
		end
	endtask

	// desc is the descriptor as the kernel sees it, data in job_words.
	task automatic run_job(input logic [shell_pkg::DATA_W-1:0] desc);
		logic [shell_pkg::DATA_W-1:0] sum;
		logic [shell_pkg::DATA_W-1:0] rd;
		int                           n;
		n   = int'(desc[shell_pkg::COUNT_W-1:0]);
		sum = '0;
		host_write('0, byte_reverse(desc));
		for (int i = 1; i <= n; i++) begin
			host_write(shell_pkg::ADDR_W'(i), job_words[i]);
			sum = sum + byte_reverse(job_words[i]);
		end
		host_write(shell_pkg::FLAG_ADDR, shell_pkg::CMD_START);
		host_read(shell_pkg::FLAG_ADDR, rd); // issued the cycle after start.
		check_flag(shell_pkg::FLAG_ACK, rd);
		wait_flag(shell_pkg::FLAG_DONE);
		host_read(shell_pkg::ADDR_W'(n + 1), rd);
		check_word(byte_reverse(sum), rd);
	endtask

	task automatic test_reset_state();
		logic [shell_pkg::DATA_W-1:0] rd;
		start_test("reset_state");
		host_read(shell_pkg::FLAG_ADDR, rd);
		check_flag('0, rd);
		host_read(21'd0, rd);
		check_word('0, rd);
		host_read(21'd1, rd);
		check_word('0, rd);
		host_read(21'd4095, rd);
		check_word('0, rd);
		end_test();
	endtask

	task automatic test_loopback();
		logic [shell_pkg::DATA_W-1:0] rd;
		logic [shell_pkg::DATA_W-1:0] a;
		logic [shell_pkg::DATA_W-1:0] b;
		logic [shell_pkg::DATA_W-1:0] c;
		start_test("host_loopback");
		a = next_random();
		b = next_random();
		c = next_random();
		host_write(21'd2, a);
		host_write(21'd4095, b);
		host_write(21'h01007, c); // folds onto word 7.
		host_read(21'd2, rd);
		check_word(a, rd);
		host_read(21'd4095, rd);
		check_word(b, rd);
		host_read(21'd7, rd);
		check_word(c, rd);
		end_test();
	endtask

	task automatic test_flag_write();
		logic [shell_pkg::DATA_W-1:0] rd;
		start_test("flag_write");
		host_write(21'd1, 32'h5a5a_0001);
		host_write(shell_pkg::FLAG_ADDR, 32'd5);
		repeat (8) @(negedge clk); // no job may start, nothing to wait for.
		host_read(shell_pkg::FLAG_ADDR, rd);
		check_flag(32'd5, rd);
		host_read(21'd1, rd);
		check_word(32'h5a5a_0001, rd);
		end_test();
	endtask

	task automatic test_directed_job();
		start_test("directed_job");
		job_words[1] = 32'h0102_0304;
		job_words[2] = 32'hffff_0000;
		job_words[3] = 32'h8000_0001;
		job_words[4] = 32'h00ff_ff00;
		run_job(32'h0000_0004);
		end_test();
	endtask

	task automatic test_random_jobs();
		logic [31:0] rnd;
		int          n;
		start_test("random_jobs");
		for (int j = 0; j < 3; j++) begin
			n = int'(next_random() % 64) + 1;
			for (int i = 1; i <= n; i++)
				job_words[i] = next_random();
			rnd = next_random(); // upper descriptor bits are ignored.
			run_job({rnd[31:shell_pkg::COUNT_W], shell_pkg::COUNT_W'(n)});
		end
		end_test();
	endtask

	task automatic test_zero_count();
		logic [31:0] rnd;
		start_test("zero_count_job");
		host_write(21'd1, 32'hdead_beef);
		rnd = next_random();
		run_job({rnd[31:shell_pkg::COUNT_W], {shell_pkg::COUNT_W{1'b0}}});
		end_test();
	endtask

	initial begin
		host_req  = '0;
		rst_n     = 1'b0;
		err_cnt   = 0;
		pass_cnt  = 0;
		fail_cnt  = 0;
		cycle_cnt = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		test_reset_state();
		test_loopback();
		test_flag_write();
		test_directed_job();
		test_random_jobs();
		test_zero_count();
		$display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule : shell_tb

// File: run.sh
#!/usr/bin/env bash
# Build and run the shell testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
	--top-module shell_tb \
	-Mdir obj_dir \
	-f project.f

./obj_dir/Vshell_tb > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
	exit 0
fi
exit 1

// File: project.f
source/shell_pkg.sv
source/shared_mem.sv
source/shell_ctrl.sv
source/checksum_kernel.sv
source/shell_top.sv
bench/shell_tb.sv
